// File: memoryGame.f
logic/gamePkg.sv
logic/sequenceRom.sv
logic/playTimer.sv
logic/gameDatapath.sv
logic/gameControl.sv
logic/memoryGame.sv
testbench/memoryGame_sva.sv
testbench/memoryGame_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the memoryGame testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module memoryGame_tb \
    -f memoryGame.f -Mdir build -o memoryGame_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Compile failed, see build.log"
    exit 1
fi

./build/memoryGame_sim > sim.log 2>&1
simStatus=$?
if grep -q "TESTS FAILED" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulation stopped with status $simStatus, see sim.log"
    exit 1
fi
echo "Simulation finished cleanly"

// File: testbench/memoryGame_golden.txt
# q: key table by position (hex), s: LFSR seed (hex)
# g: longGame fastMode keyCount, then key (hex, r = random wrong) and gap per key, outcome w/l/t
q 1 2 4 8 2 1 8 4 4 4 1 2 8 8 2 1
s 416bee2b
g 0 0 8 1 6 2 6 4 6 8 6 2 6 1 6 8 6 4 6 w
g 1 0 16 1 6 2 6 4 6 8 6 2 6 1 6 8 6 4 6 4 6 4 6 1 6 2 6 8 6 8 6 2 6 1 6 w
g 0 0 4 1 6 2 6 4 6 2 6 l
g 1 0 11 1 6 2 6 4 6 8 6 2 6 1 6 8 6 4 6 4 6 4 6 r 6 l
g 0 0 3 1 6 2 6 r 6 l
g 0 0 3 1 6 2 6 4 60 t
g 0 1 3 1 6 2 6 4 30 t
g 0 0 8 1 6 2 30 4 30 8 6 2 6 1 6 8 6 4 30 w
g 1 1 1 2 6 l

// File: testbench/memoryGame_tb.sv
`timescale 1ns/1ns

module memoryGame_tb
    import gamePkg::*;
;

    localparam int TimeLimit = 40;

    logic                clock;
    logic                reset;
    logic                start;
    logic                longGame;
    logic                fastMode;
    logic                keyValid;
    logic [KeyWidth-1:0] key;
    logic                done;
    logic                hit;
    logic                miss;
    logic                timedOutFlag;
    logic [3:0]          stateDebug;

    // Games read from the golden file
    logic [KeyWidth-1:0] sequenceTable [LongLength];
    logic [31:0]         lfsr = 32'h416bee2b;
    int                  gameLevel[$];
    int                  gameCount[$];
    byte                 gameOutcome[$];
    int                  keyValue[$];
    int                  keyGap[$];
    int                  watchCycles = 0;

    memoryGame #(.TimeLimit(TimeLimit)) u_memoryGame (.*);

    bind memoryGame memoryGame_sva u_memoryGame_sva (.*);

    always #2 clock = ~clock;

    // Galois LFSR stepped once per bit taken
    function automatic logic [KeyWidth-1:0] randomKey();
        logic [KeyWidth-1:0] value;
        for (int b = 0; b < KeyWidth; b++) begin
            value[b] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return value;
    endfunction

    task automatic reportFailure(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compareBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            reportFailure($sformatf("mismatch at %0t ns: %s expected %b got %b",
                                    $time, name, expected, actual));
        end
    endtask

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic checkOutcome(input byte code);
        compareBit("done", 1'b1, done);
        compareBit("hit", code == "w", hit);
        compareBit("miss", code != "w", miss);
        compareBit("timedOutFlag", code == "t", timedOutFlag);
    endtask

    task automatic checkState(input gameState expected);
        if (stateDebug !== expected) begin
            reportFailure($sformatf("mismatch at %0t ns: stateDebug expected %h (%s) got %h",
                                    $time, expected, expected.name(), stateDebug));
        end
    endtask

    task automatic waitCycles(input int count);
        repeat (count) @(posedge clock);
        #1;
    endtask

    task automatic strobeKey(input logic [KeyWidth-1:0] value);
        keyValid = 1'b1;
        key = value;
        waitCycles(1);
        keyValid = 1'b0;
    endtask

    task automatic readGolden();
        int                 fd;
        int                 level;
        int                 fast;
        int                 count;
        int                 gap;
        int                 budget;
        string              token;
        logic [8*256-1:0]   rest;
        budget = 200;
        fd = $fopen("testbench/memoryGame_golden.txt", "r");
        if (fd == 0) begin
            reportFailure("the golden file could not be opened");
        end
        while ($fscanf(fd, "%s", token) == 1) begin
            if (token == "#") begin
                void'($fgets(rest, fd));
            end else if (token == "q") begin
                foreach (sequenceTable[i]) begin
                    void'($fscanf(fd, "%h", sequenceTable[i]));
                end
            end else if (token == "s") begin
                void'($fscanf(fd, "%h", lfsr));
            end else if (token == "g") begin
                void'($fscanf(fd, "%d %d %d", level, fast, count));
                gameLevel.push_back(level * 2 + fast);
                gameCount.push_back(count);
                repeat (count) begin
                    void'($fscanf(fd, "%s %d", token, gap));
                    keyValue.push_back(token == "r" ? -1 : token.atohex());
                    keyGap.push_back(gap);
                    budget += gap;
                end
                void'($fscanf(fd, "%s", token));
                gameOutcome.push_back(token[0]);
                budget += 2 * TimeLimit;
            end else begin
                reportFailure({"the golden file holds an unknown record ", token});
            end
        end
        $fclose(fd);
        watchCycles = budget;
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int                  keyIndex;
        int                  count;
        int                  waited;
        byte                 outcome;
        logic [KeyWidth-1:0] value;
        clock = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        longGame = 1'b0;
        fastMode = 1'b0;
        keyValid = 1'b0;
        key = '0;
        readGolden();
        waitCycles(5);
        reset = 1'b0;
        checkState(idle);
        compareBit("done", 1'b0, done);
        compareBit("hit", 1'b0, hit);
        compareBit("miss", 1'b0, miss);
        compareBit("timedOutFlag", 1'b0, timedOutFlag);
        // A key in idle is dropped
        strobeKey(4'h1);
        waitCycles(3);
        checkState(idle);
        keyIndex = 0;
        foreach (gameCount[g]) begin
            outcome = gameOutcome[g];
            count = gameCount[g];
            longGame = gameLevel[g][1];
            fastMode = gameLevel[g][0];
            start = 1'b1;
            waitCycles(1);
            start = 1'b0;
            for (int k = 0; k < count; k++) begin
                waitCycles(keyGap[keyIndex] - 1);
                if (k < count - 1 || outcome != "t") begin
                    checkState(waitPlay);
                end
                if (keyValue[keyIndex] < 0) begin
                    // Redrawn until wrong for this position
                    do begin
                        value = randomKey();
                    end while (value == sequenceTable[k]);
                end else begin
                    value = KeyWidth'(keyValue[keyIndex]);
                end
                strobeKey(value);
                keyIndex++;
            end
            if (outcome == "t") begin
                waited = 0;
                while (!done && waited < 2 * TimeLimit) begin
                    waitCycles(1);
                    waited++;
                end
            end else begin
                // Result shows on the third cycle after the deciding key
                waitCycles(1);
                checkState(comparePlay);
                waitCycles(1);
            end
            checkOutcome(outcome);
            // Keys in an end state leave the outcome alone
            strobeKey(sequenceTable[0]);
            waitCycles(3);
            checkOutcome(outcome);
        end
        $display("TESTS PASSED");
        $finish;
    end

    // Watchdog sized from the golden file
    initial begin
        wait (watchCycles > 0);
        repeat (watchCycles) @(posedge clock);
        reportFailure("watchdog expired because the simulation hung");
    end

endmodule

// File: testbench/memoryGame_sva.sv
`timescale 1ns/1ns

module memoryGame_sva
    import gamePkg::*;
(
    input logic       clock,
    input logic       reset,
    input logic       done,
    input logic       hit,
    input logic       miss,
    input logic       timedOutFlag,
    input logic [3:0] stateDebug
);

    // ------------------------------
    // Outcome and state checks
    // ------------------------------
    legalState: assert property (@(posedge clock) disable iff (reset)
        stateDebug inside {idle, initialize, waitPlay, registerPlay, comparePlay,
                           advance, win, lose, timedOut})
        else $error("stateDebug holds an illegal code %h", stateDebug);

    singleResult: assert property (@(posedge clock) disable iff (reset) !(hit && miss))
        else $error("hit and miss are high together");

    timeoutIsLoss: assert property (@(posedge clock) disable iff (reset)
        timedOutFlag |-> (miss && done))
        else $error("timedOutFlag without miss and done");

    // An ended game always carries a result
    doneHasResult: assert property (@(posedge clock) disable iff (reset)
        done |-> (hit || miss))
        else $error("done without hit or miss");

endmodule

// File: logic/memoryGame.sv
`timescale 1ns/1ns

module memoryGame
    import gamePkg::*;
#(
    parameter int TimeLimit = 40
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                start,
    input  logic                longGame,
    input  logic                fastMode,
    input  logic                keyValid,
    input  logic [KeyWidth-1:0] key,
    output logic                done,
    output logic                hit,
    output logic                miss,
    output logic                timedOutFlag,
    output logic [3:0]          stateDebug
);

    // Control to datapath
    logic clearCounter;
    logic countUp;
    logic clearKey;
    logic loadKey;
    logic loadLevel;
    logic clearTimer;
    logic timerRun;

    // Datapath status
    logic keyMatch;
    logic lastPlay;
    logic timeUp;

    gameState currentState;

    // ------------------------------
    // Control unit
    // ------------------------------
    gameControl u_gameControl (
        .clock        (clock),
        .reset        (reset),
        .start        (start),
        .keyValid     (keyValid),
        .keyMatch     (keyMatch),
        .lastPlay     (lastPlay),
        .timeUp       (timeUp),
        .clearCounter (clearCounter),
        .countUp      (countUp),
        .clearKey     (clearKey),
        .loadKey      (loadKey),
        .loadLevel    (loadLevel),
        .clearTimer   (clearTimer),
        .timerRun     (timerRun),
        .done         (done),
        .hit          (hit),
        .miss         (miss),
        .timedOutFlag (timedOutFlag),
        .state        (currentState)
    );

    // ------------------------------
    // Datapath
    // ------------------------------
    gameDatapath #(
        .TimeLimit (TimeLimit)
    ) u_gameDatapath (
        .clock        (clock),
        .reset        (reset),
        .longGame     (longGame),
        .fastMode     (fastMode),
        .key          (key),
        .clearCounter (clearCounter),
        .countUp      (countUp),
        .clearKey     (clearKey),
        .loadKey      (loadKey),
        .loadLevel    (loadLevel),
        .clearTimer   (clearTimer),
        .timerRun     (timerRun),
        .keyMatch     (keyMatch),
        .lastPlay     (lastPlay),
        .timeUp       (timeUp)
    );

    // State code for debug
    assign stateDebug = currentState;

endmodule

// File: logic/gameControl.sv
`timescale 1ns/1ns

module gameControl
    import gamePkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     start,
    input  logic     keyValid,
    input  logic     keyMatch,
    input  logic     lastPlay,
    input  logic     timeUp,
    output logic     clearCounter,
    output logic     countUp,
    output logic     clearKey,
    output logic     loadKey,
    output logic     loadLevel,
    output logic     clearTimer,
    output logic     timerRun,
    output logic     done,
    output logic     hit,
    output logic     miss,
    output logic     timedOutFlag,
    output gameState state
);

    gameState nextState;

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    // ------------------------------
    // Next-state logic
    // ------------------------------
    always_comb begin
        nextState = state;
        case (state)
            idle:         nextState = start ? initialize : idle;
            initialize:   nextState = waitPlay;
            waitPlay: begin
                // A key on the same cycle as the timeout still counts
                if (keyValid) begin
                    nextState = registerPlay;
                end else if (timeUp) begin
                    nextState = timedOut;
                end
            end
            registerPlay: nextState = comparePlay;
            comparePlay: begin
                if (!keyMatch) begin
                    nextState = lose;
                end else if (lastPlay) begin
                    nextState = win;
                end else begin
                    nextState = advance;
                end
            end
            advance:      nextState = waitPlay;
            // End states wait for a new start
            win, lose, timedOut: begin
                if (start) begin
                    nextState = initialize;
                end
            end
            default:      nextState = idle;
        endcase
    end

    // ------------------------------
    // Moore output decode
    // ------------------------------
    always_comb begin
        clearCounter = (state == idle) || (state == initialize);
        countUp      = (state == advance);
        clearKey     = (state == idle);
        loadKey      = (state == registerPlay);
        loadLevel    = (state == initialize);
        clearTimer   = (state == initialize) || (state == registerPlay);
        timerRun     = (state == waitPlay);
        done         = (state == win) || (state == lose) || (state == timedOut);
        hit          = (state == win);
        miss         = (state == lose) || (state == timedOut);
        timedOutFlag = (state == timedOut);
    end

endmodule

// File: logic/gameDatapath.sv
`timescale 1ns/1ns

module gameDatapath
    import gamePkg::*;
#(
    parameter int TimeLimit = 40
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                longGame,
    input  logic                fastMode,
    input  logic [KeyWidth-1:0] key,
    input  logic                clearCounter,
    input  logic                countUp,
    input  logic                clearKey,
    input  logic                loadKey,
    input  logic                loadLevel,
    input  logic                clearTimer,
    input  logic                timerRun,
    output logic                keyMatch,
    output logic                lastPlay,
    output logic                timeUp
);

    logic [AddrWidth-1:0] position;
    logic [KeyWidth-1:0]  keyRegister;
    logic [KeyWidth-1:0]  expectedKey;
    logic                 longLevel;
    logic                 fastLevel;
    logic                 halfFlag;
    logic                 fullFlag;

    // ------------------------------
    // Position counter
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            position <= '0;
        end else if (clearCounter) begin
            position <= '0;
        end else if (countUp) begin
            position <= position + 1'b1;
        end
    end

    // Key register
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            keyRegister <= '0;
        end else if (clearKey) begin
            keyRegister <= '0;
        end else if (loadKey) begin
            keyRegister <= key;
        end
    end

    // Levels sampled once per game
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            longLevel <= 1'b0;
            fastLevel <= 1'b0;
        end else if (loadLevel) begin
            longLevel <= longGame;
            fastLevel <= fastMode;
        end
    end

    // ------------------------------
    // Sequence and timer
    // ------------------------------
    sequenceRom u_sequenceRom (
        .address  (position),
        .expected (expectedKey)
    );

    playTimer #(
        .TimeLimit (TimeLimit)
    ) u_playTimer (
        .clock       (clock),
        .reset       (reset),
        .clear       (clearTimer),
        .run         (timerRun),
        .halfReached (halfFlag),
        .fullReached (fullFlag)
    );

    // Status back to the control unit
    assign keyMatch = (keyRegister == expectedKey);
    assign lastPlay = longLevel ? (position == AddrWidth'(LongLength - 1))
                                : (position == AddrWidth'(ShortLength - 1));
    // Fast mode gives half the time per play
    assign timeUp   = fastLevel ? halfFlag : fullFlag;

endmodule

// File: logic/playTimer.sv
`timescale 1ns/1ns

module playTimer #(
    parameter int TimeLimit = 40
) (
    input  logic clock,
    input  logic reset,
    input  logic clear,
    input  logic run,
    output logic halfReached,
    output logic fullReached
);

    localparam int CountWidth = $clog2(TimeLimit + 1);

    logic [CountWidth-1:0] count;

    // ------------------------------
    // Cycle counter
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (run && !fullReached) begin
            // Holds at the limit until cleared
            count <= count + 1'b1;
        end
    end

    assign halfReached = (count >= CountWidth'(TimeLimit / 2));
    assign fullReached = (count >= CountWidth'(TimeLimit));

endmodule

// File: logic/sequenceRom.sv
`timescale 1ns/1ns

module sequenceRom
    import gamePkg::*;
(
    input  logic [AddrWidth-1:0] address,
    output logic [KeyWidth-1:0]  expected
);

    // One-hot key per position
    always_comb begin
        case (address)
            4'd0:    expected = 4'h1;
            4'd1:    expected = 4'h2;
            4'd2:    expected = 4'h4;
            4'd3:    expected = 4'h8;
            4'd4:    expected = 4'h2;
            4'd5:    expected = 4'h1;
            4'd6:    expected = 4'h8;
            4'd7:    expected = 4'h4;
            // Second half only reached in long games
            4'd8:    expected = 4'h4;
            4'd9:    expected = 4'h4;
            4'd10:   expected = 4'h1;
            4'd11:   expected = 4'h2;
            4'd12:   expected = 4'h8;
            4'd13:   expected = 4'h8;
            4'd14:   expected = 4'h2;
            4'd15:   expected = 4'h1;
            default: expected = '0;
        endcase
    end

endmodule

// File: logic/gamePkg.sv
package gamePkg;

    // ------------------------------
    // Widths and game lengths
    // ------------------------------

    // Width of one key value
    localparam int KeyWidth = 4;

    // Width of a sequence position
    localparam int AddrWidth = 4;

    // Plays per game for each level
    localparam int ShortLength = 8;
    localparam int LongLength = 16;

    // ------------------------------
    // Control states
    // ------------------------------

    // Codes follow the debug display convention
    typedef enum logic [3:0] {
        idle         = 4'h0,
        initialize   = 4'h1,
        waitPlay     = 4'h4,
        registerPlay = 4'h5,
        comparePlay  = 4'h6,
        advance      = 4'h7,
        win          = 4'hC,
        lose         = 4'hE,
        timedOut     = 4'hF
    } gameState;

endpackage
